// File: Bender.yml
package:
  name: pattern_source

sources:
  - pattern_pkg.sv
  - cmd_decoder.sv
  - bus_arbiter.sv
  - trig_wave_gen.sv
  - square_wave_gen.sv
  - prbs_gen.sv
  - pattern_top.sv
  - target: test
    files:
      - pattern_checker.sv
      - tb_pattern_top.sv

// File: bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import pattern_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   run,
  input  wave_t  req_wave,
  input  batch_t tri_batch,
  input  batch_t sq_batch,
  input  batch_t prbs_batch,
  input  logic   tri_boundary,
  input  logic   sq_boundary,
  input  logic   prbs_boundary,
  output logic   tri_en,
  output logic   sq_en,
  output logic   prbs_en,
  output batch_t batch_out,
  output logic   batch_valid,
  output wave_t  active_wave
);

  wave_t  grant;
  wave_t  src_wave;      // Generator that stepped on the last edge.
  logic   src_valid;
  logic   grant_boundary;
  batch_t src_batch;

  assign tri_en  = run && (grant == WAVE_TRI);
  assign sq_en   = run && (grant == WAVE_SQUARE);
  assign prbs_en = run && (grant == WAVE_PRBS);

  always_comb begin
    case (grant)
      WAVE_SQUARE: grant_boundary = sq_boundary;
      WAVE_PRBS:   grant_boundary = prbs_boundary;
      default:     grant_boundary = tri_boundary;
    endcase
  end

  always_comb begin
    case (src_wave)
      WAVE_SQUARE: src_batch = sq_batch;
      WAVE_PRBS:   src_batch = prbs_batch;
      default:     src_batch = tri_batch;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Grant hand-over and output stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      grant       <= WAVE_TRI;
      src_wave    <= WAVE_TRI;
      src_valid   <= 1'b0;
      batch_valid <= 1'b0;
      active_wave <= WAVE_TRI;
    end else begin
      if (!run) begin
        grant <= req_wave;                             // Idle bus, switch at once.
      end else if ((req_wave != grant) && grant_boundary) begin
        grant <= req_wave;                             // Old wave finishes this step.
      end
      src_wave    <= grant;
      src_valid   <= run;
      batch_valid <= src_valid;
      active_wave <= src_wave;
    end
  end

  always_ff @(posedge clk) begin
    if (src_valid) begin
      batch_out <= src_batch;
    end
  end

endmodule

// File: cmd_decoder.sv
`timescale 1ns/1ns

module cmd_decoder import pattern_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  cmd_t                cmd,
  output logic                run,
  output wave_t               req_wave,
  output logic [HP_WIDTH-1:0] half_period
);

  logic [HP_WIDTH-1:0] hp_arg;

  // A zero half-period would never end a phase.
  assign hp_arg = (cmd.arg[HP_WIDTH-1:0] == '0) ? HP_WIDTH'(1) : cmd.arg[HP_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      run         <= 1'b0;
      req_wave    <= WAVE_TRI;
      half_period <= HP_WIDTH'(1);
    end else if (cmd_valid) begin
      case (cmd.op)
        OP_SELECT: begin
          case (cmd.arg[1:0])
            2'd0:    req_wave <= WAVE_TRI;
            2'd1:    req_wave <= WAVE_SQUARE;
            2'd2:    req_wave <= WAVE_PRBS;
            default: req_wave <= req_wave;       // No generator on code 3.
          endcase
        end
        OP_START: begin
          run <= 1'b1;
        end
        OP_STOP: begin
          run <= 1'b0;
        end
        OP_HALF_PERIOD: begin
          half_period <= hp_arg;
        end
        default: begin
          run <= run;                            // NOP and unknown codes.
        end
      endcase
    end
  end

endmodule

// File: compile.f
pattern_pkg.sv
cmd_decoder.sv
bus_arbiter.sv
trig_wave_gen.sv
square_wave_gen.sv
prbs_gen.sv
pattern_top.sv
pattern_checker.sv
tb_pattern_top.sv

// File: pattern_checker.sv
`timescale 1ns/1ns

module pattern_checker import pattern_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  cmd_t       cmd,
  input  batch_t     batch_out,
  input  logic       batch_valid,
  input  wave_t      active_wave,
  input  logic       exp_strobe,
  input  logic [3:0] exp_code,         // 0 idle, 1 to 3 wave code plus one, else no check.
  output int         value_errors,
  output int         script_errors,
  output int         batches_checked
);

  logic                  run_m;
  wave_t                 req_m;
  int                    hp_m;
  wave_t                 grant_m;
  logic                  stage_valid;      // Generator register stage.
  wave_t                 stage_wave;
  batch_t                stage_batch;
  logic                  out_valid;        // Output register stage.
  wave_t                 out_wave;
  batch_t                out_batch;
  logic                  tri_fall;
  int                    tri_start;
  logic                  sq_high;
  int                    sq_cnt;
  int                    sq_len;           // Length of the current phase.
  logic [LFSR_WIDTH-1:0] lfsr_m;

  task automatic report_mismatch(input string name, input int exp, input int act,
                                 input bit script);
    $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    if (script) script_errors++;
    else value_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wave models
  ////////////////////////////////////////////////////////////////////////////

  function automatic int phase_len();
    return (sq_cnt == 0) ? hp_m : sq_len;   // First batch of a phase fixes its length.
  endfunction

  function automatic bit granted_boundary();
    case (grant_m)
      WAVE_TRI:    return tri_fall && (tri_start - BATCH_SAMPLES < 0);
      WAVE_SQUARE: return !sq_high && (sq_cnt == phase_len() - 1);
      default:     return 1'b1;
    endcase
  endfunction

  task automatic tri_step(output batch_t b);
    int v;
    for (int i = 0; i < BATCH_SAMPLES; i++) begin
      v = tri_fall ? tri_start - i : tri_start + i;
      if (v > FULL_SCALE) v = FULL_SCALE;
      if (v < 0) v = 0;
      b[i] = sample_t'(v);
    end
    if (!tri_fall && tri_start + BATCH_SAMPLES > FULL_SCALE) begin
      tri_fall  = 1'b1;
      tri_start = FULL_SCALE;
    end else if (tri_fall && tri_start - BATCH_SAMPLES < 0) begin
      tri_fall  = 1'b0;
      tri_start = 0;
    end else begin
      tri_start = tri_fall ? tri_start - BATCH_SAMPLES : tri_start + BATCH_SAMPLES;
    end
  endtask

  task automatic square_step(output batch_t b);
    int len;
    len    = phase_len();
    sq_len = len;
    b      = sq_high ? {BATCH_SAMPLES{sample_t'(FULL_SCALE)}} : '0;
    if (sq_cnt == len - 1) begin
      sq_cnt  = 0;
      sq_high = !sq_high;
    end else begin
      sq_cnt++;
    end
  endtask

  task automatic prbs_step(output batch_t b);
    logic fb;
    for (int i = 0; i < BATCH_SAMPLES; i++) begin
      fb     = lfsr_m[14] ^ lfsr_m[13];      // Taps of x^15 + x^14 + 1.
      lfsr_m = {lfsr_m[13:0], fb};
      b[i]   = lfsr_m[SAMPLE_WIDTH-1:0];
    end
  endtask

  task automatic advance_model();
    bit     bnd;
    batch_t b;
    bnd         = granted_boundary();
    out_valid   = stage_valid;
    out_wave    = stage_wave;
    out_batch   = stage_batch;
    stage_valid = run_m;
    stage_wave  = grant_m;
    if (run_m) begin
      case (grant_m)
        WAVE_TRI:    tri_step(b);
        WAVE_SQUARE: square_step(b);
        default:     prbs_step(b);
      endcase
      stage_batch = b;
    end
    if (!run_m || (req_m != grant_m && bnd)) grant_m = req_m;
    if (cmd_valid) begin
      case (cmd.op)
        OP_SELECT:      if (cmd.arg[1:0] != 2'd3) req_m = wave_t'(cmd.arg[1:0]);
        OP_START:       run_m = 1'b1;
        OP_STOP:        run_m = 1'b0;
        OP_HALF_PERIOD: hp_m = (cmd.arg == 0) ? 1 : int'(cmd.arg);
        default:        ;
      endcase
    end
  endtask

  task automatic check_script();
    if (exp_code == 4'd0) begin
      if (batch_valid !== 1'b0) report_mismatch("batch_valid", 0, batch_valid, 1'b1);
    end else if (exp_code <= 4'd3) begin
      if (batch_valid !== 1'b1) report_mismatch("batch_valid", 1, batch_valid, 1'b1);
      else if (int'(active_wave) != int'(exp_code) - 1)
        report_mismatch("active_wave", int'(exp_code) - 1, active_wave, 1'b1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare, then step the model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      run_m           = 1'b0;
      req_m           = WAVE_TRI;
      hp_m            = 1;
      grant_m         = WAVE_TRI;
      stage_valid     = 1'b0;
      stage_wave      = WAVE_TRI;
      out_valid       = 1'b0;
      out_wave        = WAVE_TRI;
      tri_fall        = 1'b0;
      tri_start       = 0;
      sq_high         = 1'b1;
      sq_cnt          = 0;
      sq_len          = 1;
      lfsr_m          = PRBS_SEED;
      value_errors    = 0;
      script_errors   = 0;
      batches_checked = 0;
    end else begin
      if (batch_valid !== out_valid) begin
        report_mismatch("batch_valid", out_valid, batch_valid, 1'b0);
      end else if (out_valid) begin
        batches_checked++;
        if (active_wave !== out_wave) report_mismatch("active_wave", out_wave, active_wave, 1'b0);
        for (int i = 0; i < BATCH_SAMPLES; i++) begin
          if (batch_out[i] !== out_batch[i])
            report_mismatch($sformatf("batch_out[%0d]", i), out_batch[i], batch_out[i], 1'b0);
        end
      end
      if (exp_strobe) check_script();
      advance_model();
    end
  end

endmodule

// File: pattern_pkg.sv
package pattern_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_WIDTH  = 12;
  localparam int BATCH_SAMPLES = 4;
  localparam int FULL_SCALE    = 2047;                 // Largest positive code.
  localparam int ACC_WIDTH     = SAMPLE_WIDTH + 2;     // Ramp start with headroom.
  localparam int HP_WIDTH      = 16;
  localparam int ARG_WIDTH     = 16;
  localparam int LFSR_WIDTH    = 15;

  localparam logic [LFSR_WIDTH-1:0] PRBS_SEED = 15'h7fff;

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    WAVE_TRI    = 2'd0,
    WAVE_SQUARE = 2'd1,
    WAVE_PRBS   = 2'd2
  } wave_t;

  typedef enum logic [2:0] {
    OP_NOP         = 3'd0,
    OP_SELECT      = 3'd1,
    OP_START       = 3'd2,
    OP_STOP        = 3'd3,
    OP_HALF_PERIOD = 3'd4
  } cmd_op_t;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  typedef struct packed {
    cmd_op_t              op;
    logic [ARG_WIDTH-1:0] arg;
  } cmd_t;

  // Index 0 is the first sample in time.
  typedef logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] batch_t;

endpackage

// File: pattern_top.sv
`timescale 1ns/1ns

module pattern_top import pattern_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   cmd_valid,
  input  cmd_t   cmd,
  output batch_t batch_out,
  output logic   batch_valid,
  output wave_t  active_wave
);

  logic                run;
  wave_t               req_wave;
  logic [HP_WIDTH-1:0] half_period;

  logic   tri_en;
  logic   sq_en;
  logic   prbs_en;
  batch_t tri_batch;
  batch_t sq_batch;
  batch_t prbs_batch;
  logic   tri_boundary;
  logic   sq_boundary;
  logic   prbs_boundary;

  cmd_decoder u_cmd_decoder (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .run         (run),
    .req_wave    (req_wave),
    .half_period (half_period)
  );

  bus_arbiter u_bus_arbiter (
    .clk           (clk),
    .rst           (rst),
    .run           (run),
    .req_wave      (req_wave),
    .tri_batch     (tri_batch),
    .sq_batch      (sq_batch),
    .prbs_batch    (prbs_batch),
    .tri_boundary  (tri_boundary),
    .sq_boundary   (sq_boundary),
    .prbs_boundary (prbs_boundary),
    .tri_en        (tri_en),
    .sq_en         (sq_en),
    .prbs_en       (prbs_en),
    .batch_out     (batch_out),
    .batch_valid   (batch_valid),
    .active_wave   (active_wave)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Pattern generators
  ////////////////////////////////////////////////////////////////////////////

  trig_wave_gen u_trig_wave_gen (
    .clk      (clk),
    .rst      (rst),
    .en       (tri_en),
    .batch    (tri_batch),
    .boundary (tri_boundary)
  );

  square_wave_gen u_square_wave_gen (
    .clk         (clk),
    .rst         (rst),
    .en          (sq_en),
    .half_period (half_period),
    .batch       (sq_batch),
    .boundary    (sq_boundary)
  );

  prbs_gen u_prbs_gen (
    .clk      (clk),
    .rst      (rst),
    .en       (prbs_en),
    .batch    (prbs_batch),
    .boundary (prbs_boundary)
  );

endmodule

// File: pattern_vectors.txt
# Columns: opcode (hex), argument (hex), wait cycles, expected bus state after the wait
# Opcodes: 0 NOP, 1 SELECT, 2 START, 3 STOP, 4 HALF_PERIOD, 7 unknown
# Bus state: 0 idle, 1 triangle, 2 square, 3 PRBS, 9 no check
0 0000 4 0
2 0000 1100 1
3 0000 6 0
1 0001 4 0
4 0005 4 0
2 0000 12 2
4 0002 30 2
1 0002 40 3
0 0000 400 3
1 0000 10 1
0 0000 200 1
1 0001 8 1
0 0000 800 2
3 0000 6 0
2 0000 8 2
1 0002 20 3
0 0000 300 3
3 0000 6 0
1 0000 4 0
2 0000 20 1
3 0000 6 0
1 0001 4 0
4 0000 4 0
2 0000 30 2
1 0003 10 2
7 0000 4 2
3 0000 6 0
0 0000 4 0

// File: prbs_gen.sv
`timescale 1ns/1ns

module prbs_gen import pattern_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   en,
  output batch_t batch,
  output logic   boundary
);

  logic [LFSR_WIDTH-1:0] lfsr;
  logic [LFSR_WIDTH-1:0] step_state;
  logic [LFSR_WIDTH-1:0] nxt_lfsr;
  batch_t                nxt_batch;

  ////////////////////////////////////////////////////////////////////////////
  // Unrolled LFSR steps, x^15 + x^14 + 1
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    step_state = lfsr;
    for (int i = 0; i < BATCH_SAMPLES; i++) begin
      step_state   = {step_state[LFSR_WIDTH-2:0],
                      step_state[LFSR_WIDTH-1] ^ step_state[LFSR_WIDTH-2]};
      nxt_batch[i] = step_state[SAMPLE_WIDTH-1:0];   // Low bits after step i+1.
    end
    nxt_lfsr = step_state;
  end

  // Every batch is a clean point to hand the bus over.
  assign boundary = en;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= PRBS_SEED;
    end else if (en) begin
      lfsr <= nxt_lfsr;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      batch <= nxt_batch;
    end
  end

endmodule

// File: square_wave_gen.sv
`timescale 1ns/1ns

module square_wave_gen import pattern_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  logic [HP_WIDTH-1:0] half_period,
  output batch_t              batch,
  output logic                boundary
);

  logic                phase;        // High while emitting full scale.
  logic [HP_WIDTH-1:0] count;        // Batches done in this phase.
  logic [HP_WIDTH-1:0] hp_q;
  logic [HP_WIDTH-1:0] limit;
  logic                last;

  // First batch of a phase uses the live value; the rest use the copy.
  assign limit = (count == '0) ? half_period : hp_q;
  assign last  = (count == limit - HP_WIDTH'(1));

  assign boundary = !phase && last;  // Last low batch ends the period.

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= 1'b1;
      count <= '0;
      hp_q  <= HP_WIDTH'(1);
    end else if (en) begin
      if (count == '0) begin
        hp_q <= half_period;
      end
      if (last) begin
        count <= '0;
        phase <= !phase;
      end else begin
        count <= count + HP_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (phase) begin
        batch <= {BATCH_SAMPLES{sample_t'(FULL_SCALE)}};
      end else begin
        batch <= '0;
      end
    end
  end

endmodule

// File: tb_pattern_top.sv
`timescale 1ns/1ns

module tb_pattern_top import pattern_pkg::*; ();

  logic       clk;
  logic       rst;
  logic       cmd_valid;
  cmd_t       cmd;
  batch_t     batch_out;
  logic       batch_valid;
  wave_t      active_wave;
  logic       exp_strobe;
  logic [3:0] exp_code;
  int         value_errors;
  int         script_errors;
  int         batches_checked;
  int         vec_op[$];
  int         vec_arg[$];
  int         vec_wait[$];
  int         vec_code[$];
  int         seed = 86474;
  int         cycle_limit = 0;
  int         cycle_count = 0;
  int         gap;
  bit         file_ok;

  pattern_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .batch_out   (batch_out),
    .batch_valid (batch_valid),
    .active_wave (active_wave)
  );

  pattern_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .cmd_valid       (cmd_valid),
    .cmd             (cmd),
    .batch_out       (batch_out),
    .batch_valid     (batch_valid),
    .active_wave     (active_wave),
    .exp_strobe      (exp_strobe),
    .exp_code        (exp_code),
    .value_errors    (value_errors),
    .script_errors   (script_errors),
    .batches_checked (batches_checked)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the command script did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic read_vectors(output bit ok);
    int    fd;
    int    n;
    int    op;
    int    arg;
    int    wait_cycles;
    int    code;
    string line;
    ok = 1'b0;
    fd = $fopen("pattern_vectors.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %d %d", op, arg, wait_cycles, code);
          if (n == 4) begin
            vec_op.push_back(op);
            vec_arg.push_back(arg);
            vec_wait.push_back(wait_cycles);
            vec_code.push_back(code);
            cycle_limit += wait_cycles + 5;      // Command, release and the longest gap.
          end
        end
      end
      $fclose(fd);
      ok = (vec_op.size() > 0);
      cycle_limit += 64;
    end
  endtask

  task automatic send_command(input int op, input int arg, input int wait_cycles,
                              input int code);
    @(posedge clk);
    exp_strobe <= 1'b0;
    cmd_valid  <= 1'b1;
    cmd        <= {3'(op), 16'(arg)};
    @(posedge clk);
    cmd_valid  <= 1'b0;
    cmd        <= '0;
    repeat (wait_cycles) @(posedge clk);
    exp_code   <= 4'(code);
    exp_strobe <= 1'b1;                       // Checked once on the next edge.
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    exp_strobe = 1'b0;
    exp_code   = 4'd9;
    read_vectors(file_ok);
    if (!file_ok) begin
      $display("Could not read any command from pattern_vectors.txt");
      $display("TESTS FAILED");
      $finish;
    end else begin
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < vec_op.size(); i++) begin
        send_command(vec_op[i], vec_arg[i], vec_wait[i], vec_code[i]);
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
          @(posedge clk);
          exp_strobe <= 1'b0;
        end
      end
      @(posedge clk);
      exp_strobe <= 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      $display("Errors: %0d value, %0d script; %0d batches checked",
               value_errors, script_errors, batches_checked);
      if (value_errors == 0 && script_errors == 0 && batches_checked > 0)
        $display("TESTS PASSED");
      else
        $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

// File: trig_wave_gen.sv
`timescale 1ns/1ns

module trig_wave_gen import pattern_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   en,
  output batch_t batch,
  output logic   boundary
);

  typedef enum logic {
    RISE,
    FALL
  } tri_state_t;

  tri_state_t                  state;
  logic signed [ACC_WIDTH-1:0] start;        // First sample of the current batch.
  logic signed [ACC_WIDTH-1:0] nxt_start;
  logic                        turn;
  batch_t                      nxt_batch;
  int                          raw;
  int                          clamped;

  ////////////////////////////////////////////////////////////////////////////
  // Next batch
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    raw     = 0;
    clamped = 0;
    for (int i = 0; i < BATCH_SAMPLES; i++) begin
      if (state == RISE) begin
        raw = int'(start) + i;
      end else begin
        raw = int'(start) - i;
      end
      if (raw > FULL_SCALE) begin
        clamped = FULL_SCALE;                // Top of the ramp.
      end else if (raw < 0) begin
        clamped = 0;                         // Bottom of the ramp.
      end else begin
        clamped = raw;
      end
      nxt_batch[i] = sample_t'(clamped);
    end
  end

  always_comb begin
    if (state == RISE) begin
      nxt_start = start + ACC_WIDTH'(BATCH_SAMPLES);
      turn      = (int'(nxt_start) > FULL_SCALE);
    end else begin
      nxt_start = start - ACC_WIDTH'(BATCH_SAMPLES);
      turn      = (nxt_start < 0);
    end
  end

  // Next batch starts rising from zero again.
  assign boundary = (state == FALL) && turn;

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RISE;
      start <= '0;
    end else if (en) begin
      if (turn) begin
        if (state == RISE) begin
          state <= FALL;
          start <= ACC_WIDTH'(FULL_SCALE);
        end else begin
          state <= RISE;
          start <= '0;
        end
      end else begin
        start <= nxt_start;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      batch <= nxt_batch;
    end
  end

endmodule
